// ==== rtl/dcache_cfg.svh ====
/*
 * dcache configuration
 * widths of the address split and the size of the tag and data arrays
 * for the two-way write-back data cache
 */
`ifndef DCACHE_CFG_SVH
`define DCACHE_CFG_SVH

// cpu side
`define DCACHE_ADDR_W   32
`define DCACHE_DATA_W   64
`define DCACHE_STRB_W   8

// one 64-bit word per set
`define DCACHE_SETS     64
`define DCACHE_INDEX_W  6
`define DCACHE_OFFSET_W 3

// what is left of the address after index and byte offset
`define DCACHE_TAG_W    (`DCACHE_ADDR_W - `DCACHE_INDEX_W - `DCACHE_OFFSET_W)

`endif

// ==== rtl/dcache_pkg.sv ====
/*
 * dcache types
 * address fields, data words, controller states and
 * memory port operation codes shared by the cache blocks
 */
`include "dcache_cfg.svh"

package dcache_pkg;

    typedef logic [`DCACHE_ADDR_W-1:0]  addr_t;
    typedef logic [`DCACHE_DATA_W-1:0]  word_t;
    typedef logic [`DCACHE_STRB_W-1:0]  strb_t;
    typedef logic [`DCACHE_INDEX_W-1:0] index_t;
    typedef logic [`DCACHE_TAG_W-1:0]   tag_t;
    typedef logic                       way_t;

    // one-hot controller states
    typedef enum logic [5:0] {
        S_IDLE      = 6'b000001,
        S_LOOKUP    = 6'b000010,
        S_COMPARE   = 6'b000100,
        S_WRITEBACK = 6'b001000,
        S_REFILL    = 6'b010000,
        S_RESPOND   = 6'b100000
    } state_t;

    typedef enum logic [1:0] {
        MEM_NONE      = 2'b00,
        MEM_WRITEBACK = 2'b01,
        MEM_REFILL    = 2'b10
    } mem_op_t;

endpackage

// ==== rtl/dcache_sram.sv ====
/*
 * dcache array
 * single-port synchronous array with one entry per set,
 * registered read, used for both the tag and the data ways
 */
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_sram #(
    parameter type entry_t = logic
) (
    input  logic                clk,
    input  logic                en_i,
    input  logic                we_i,
    input  dcache_pkg::index_t  addr_i,
    input  entry_t              wdata_i,
    output entry_t              rdata_o
);

    entry_t mem_q [`DCACHE_SETS];

    // write wins, a read only happens on a cycle without write
    always_ff @(posedge clk) begin
        if (we_i) begin
            mem_q[addr_i] <= wdata_i;
        end else if (en_i) begin
            rdata_o <= mem_q[addr_i];
        end
    end

endmodule

// ==== rtl/dcache_lookup.sv ====
/*
 * dcache lookup
 * valid, dirty and lru state per way and set, tag compare
 * and victim choice for the two-way data cache
 */
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_lookup (
    input  logic                clk,
    input  logic                reset_i,
    input  dcache_pkg::index_t  index_i,
    input  dcache_pkg::tag_t    tag_i,
    input  dcache_pkg::tag_t    way0_tag_i,
    input  dcache_pkg::tag_t    way1_tag_i,
    input  logic                fill_i,
    input  dcache_pkg::way_t    fill_way_i,
    input  logic                mark_dirty_i,
    input  dcache_pkg::way_t    dirty_way_i,
    input  logic                touch_i,
    input  dcache_pkg::way_t    touch_way_i,
    output logic                hit_o,
    output dcache_pkg::way_t    hit_way_o,
    output dcache_pkg::way_t    victim_way_o,
    output logic                victim_dirty_o,
    output dcache_pkg::tag_t    victim_tag_o
);

    logic [`DCACHE_SETS-1:0] valid_q [2];
    logic [`DCACHE_SETS-1:0] dirty_q [2];
    // way used last in each set
    logic [`DCACHE_SETS-1:0] mru_q;

    logic hit0;
    logic hit1;

    assign hit0 = valid_q[0][index_i] && (way0_tag_i == tag_i);
    assign hit1 = valid_q[1][index_i] && (way1_tag_i == tag_i);

    assign hit_o     = hit0 || hit1;
    assign hit_way_o = hit1;

    // first invalid way, else the one not used last
    always_comb begin
        if (!valid_q[0][index_i]) begin
            victim_way_o = 1'b0;
        end else if (!valid_q[1][index_i]) begin
            victim_way_o = 1'b1;
        end else begin
            victim_way_o = ~mru_q[index_i];
        end
    end

    assign victim_dirty_o = dirty_q[victim_way_o][index_i];
    assign victim_tag_o   = victim_way_o ? way1_tag_i : way0_tag_i;

    always_ff @(posedge clk) begin
        if (reset_i) begin
            valid_q[0] <= '0;
            valid_q[1] <= '0;
            dirty_q[0] <= '0;
            dirty_q[1] <= '0;
            mru_q      <= '0;
        end else begin
            if (fill_i) begin
                valid_q[fill_way_i][index_i] <= 1'b1;
                dirty_q[fill_way_i][index_i] <= 1'b0;
            end
            if (mark_dirty_i) begin
                dirty_q[dirty_way_i][index_i] <= 1'b1;
            end
            if (touch_i) begin
                mru_q[index_i] <= touch_way_i;
            end
        end
    end

endmodule

// ==== rtl/dcache_ctrl.sv ====
/*
 * dcache controller
 * captures one cpu request at a time, runs the lookup, write-back
 * and refill sequence, merges store bytes into the hit word and
 * drives the memory line port
 */
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_ctrl (
    input  logic                 clk,
    input  logic                 reset_i,
    // cpu request port
    input  logic                 req_valid_i,
    input  logic                 req_write_i,
    input  dcache_pkg::addr_t    req_addr_i,
    input  dcache_pkg::word_t    req_wdata_i,
    input  dcache_pkg::strb_t    req_strb_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output dcache_pkg::word_t    resp_rdata_o,
    // memory line port
    output dcache_pkg::mem_op_t  mem_op_o,
    output dcache_pkg::addr_t    mem_addr_o,
    output dcache_pkg::word_t    mem_wdata_o,
    input  logic                 mem_ready_i,
    input  dcache_pkg::word_t    mem_rdata_i,
    // arrays
    output dcache_pkg::index_t   arr_index_o,
    output logic                 arr_en_o,
    output logic                 way0_we_o,
    output logic                 way1_we_o,
    output dcache_pkg::tag_t     arr_wtag_o,
    output dcache_pkg::word_t    arr_wdata_o,
    input  dcache_pkg::word_t    way0_data_i,
    input  dcache_pkg::word_t    way1_data_i,
    // lookup events
    output logic                 fill_o,
    output dcache_pkg::way_t     fill_way_o,
    output logic                 mark_dirty_o,
    output dcache_pkg::way_t     dirty_way_o,
    output logic                 touch_o,
    output dcache_pkg::way_t     touch_way_o,
    // lookup results
    input  logic                 hit_i,
    input  dcache_pkg::way_t     hit_way_i,
    input  dcache_pkg::way_t     victim_way_i,
    input  logic                 victim_dirty_i,
    input  dcache_pkg::tag_t     victim_tag_i
);

    dcache_pkg::state_t  state_q;
    dcache_pkg::state_t  state_d;

    dcache_pkg::addr_t   addr_q;
    logic                write_q;
    dcache_pkg::word_t   wdata_q;
    dcache_pkg::strb_t   strb_q;

    dcache_pkg::index_t  index;
    dcache_pkg::tag_t    tag;
    dcache_pkg::word_t   hit_word;
    dcache_pkg::word_t   victim_word;
    dcache_pkg::word_t   merged_word;
    dcache_pkg::word_t   resp_word_q;

    dcache_pkg::mem_op_t mem_op_q;
    dcache_pkg::addr_t   mem_addr_q;
    dcache_pkg::word_t   mem_wdata_q;
    dcache_pkg::way_t    victim_q;

    logic                hit_write;
    logic                refill_done;

    assign index = addr_q[`DCACHE_OFFSET_W +: `DCACHE_INDEX_W];
    assign tag   = addr_q[`DCACHE_ADDR_W-1 -: `DCACHE_TAG_W];

    assign hit_word    = hit_way_i ? way1_data_i : way0_data_i;
    assign victim_word = victim_way_i ? way1_data_i : way0_data_i;

    // strobed bytes from the request, the rest from the cached word
    always_comb begin
        merged_word = hit_word;
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            if (strb_q[b]) begin
                merged_word[8*b +: 8] = wdata_q[8*b +: 8];
            end
        end
    end

    assign hit_write   = (state_q == dcache_pkg::S_COMPARE) && hit_i && write_q;
    assign refill_done = (state_q == dcache_pkg::S_REFILL) &&
                         (mem_op_q == dcache_pkg::MEM_REFILL) && mem_ready_i;

    always_comb begin
        state_d = state_q;
        unique case (state_q)
            dcache_pkg::S_IDLE: begin
                if (req_valid_i) begin
                    state_d = dcache_pkg::S_LOOKUP;
                end
            end
            dcache_pkg::S_LOOKUP: begin
                state_d = dcache_pkg::S_COMPARE;
            end
            dcache_pkg::S_COMPARE: begin
                if (hit_i) begin
                    state_d = dcache_pkg::S_RESPOND;
                end else if (victim_dirty_i) begin
                    state_d = dcache_pkg::S_WRITEBACK;
                end else begin
                    state_d = dcache_pkg::S_REFILL;
                end
            end
            dcache_pkg::S_WRITEBACK: begin
                if (mem_ready_i) begin
                    state_d = dcache_pkg::S_REFILL;
                end
            end
            dcache_pkg::S_REFILL: begin
                // refilled line is looked up again and then hits
                if (refill_done) begin
                    state_d = dcache_pkg::S_LOOKUP;
                end
            end
            dcache_pkg::S_RESPOND: begin
                state_d = dcache_pkg::S_IDLE;
            end
            default: begin
                state_d = dcache_pkg::S_IDLE;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            state_q <= dcache_pkg::S_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    always_ff @(posedge clk) begin
        if (req_valid_i && req_ready_o) begin
            addr_q  <= req_addr_i;
            write_q <= req_write_i;
            wdata_q <= req_wdata_i;
            strb_q  <= req_strb_i;
        end
    end

    // op goes back to none the cycle after ready, also between write-back and refill
    always_ff @(posedge clk) begin
        if (reset_i) begin
            mem_op_q <= dcache_pkg::MEM_NONE;
        end else if ((state_q == dcache_pkg::S_COMPARE) && !hit_i && victim_dirty_i) begin
            mem_op_q <= dcache_pkg::MEM_WRITEBACK;
        end else if ((state_q == dcache_pkg::S_REFILL) && (mem_op_q == dcache_pkg::MEM_NONE)) begin
            mem_op_q <= dcache_pkg::MEM_REFILL;
        end else if (mem_ready_i) begin
            mem_op_q <= dcache_pkg::MEM_NONE;
        end
    end

    always_ff @(posedge clk) begin
        if (state_q == dcache_pkg::S_COMPARE) begin
            mem_addr_q  <= {victim_tag_i, index, {`DCACHE_OFFSET_W{1'b0}}};
            mem_wdata_q <= victim_word;
            victim_q    <= victim_way_i;
            resp_word_q <= hit_word;
        end else if ((state_q == dcache_pkg::S_REFILL) && (mem_op_q == dcache_pkg::MEM_NONE)) begin
            mem_addr_q <= {tag, index, {`DCACHE_OFFSET_W{1'b0}}};
        end
    end

    assign mem_op_o    = mem_op_q;
    assign mem_addr_o  = mem_addr_q;
    assign mem_wdata_o = mem_wdata_q;

    assign req_ready_o  = (state_q == dcache_pkg::S_IDLE);
    assign resp_valid_o = (state_q == dcache_pkg::S_RESPOND);
    assign resp_rdata_o = (resp_valid_o && !write_q) ? resp_word_q : '0;

    // arrays always addressed by the captured request
    assign arr_index_o = index;
    assign arr_en_o    = (state_q == dcache_pkg::S_LOOKUP);
    assign arr_wtag_o  = tag;
    assign arr_wdata_o = refill_done ? mem_rdata_i : merged_word;
    assign way0_we_o   = (hit_write && (hit_way_i == 1'b0)) ||
                         (refill_done && (victim_q == 1'b0));
    assign way1_we_o   = (hit_write && (hit_way_i == 1'b1)) ||
                         (refill_done && (victim_q == 1'b1));

    assign fill_o       = refill_done;
    assign fill_way_o   = victim_q;
    assign mark_dirty_o = hit_write;
    assign dirty_way_o  = hit_way_i;
    assign touch_o      = (state_q == dcache_pkg::S_COMPARE) && hit_i;
    assign touch_way_o  = hit_way_i;

endmodule

// ==== rtl/dcache_top.sv ====
/*
 * dcache top
 * two-way write-back data cache, 64 sets of one word,
 * controller, lookup state and the tag and data arrays
 */
`timescale 1ns/1ns

module dcache_top (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 req_valid_i,
    input  logic                 req_write_i,
    input  dcache_pkg::addr_t    req_addr_i,
    input  dcache_pkg::word_t    req_wdata_i,
    input  dcache_pkg::strb_t    req_strb_i,
    output logic                 req_ready_o,
    output logic                 resp_valid_o,
    output dcache_pkg::word_t    resp_rdata_o,
    output dcache_pkg::mem_op_t  mem_op_o,
    output dcache_pkg::addr_t    mem_addr_o,
    output dcache_pkg::word_t    mem_wdata_o,
    input  logic                 mem_ready_i,
    input  dcache_pkg::word_t    mem_rdata_i
);

    dcache_pkg::index_t arr_index;
    logic               arr_en;
    logic               way0_we;
    logic               way1_we;
    dcache_pkg::tag_t   arr_wtag;
    dcache_pkg::word_t  arr_wdata;
    dcache_pkg::tag_t   way0_tag;
    dcache_pkg::tag_t   way1_tag;
    dcache_pkg::word_t  way0_data;
    dcache_pkg::word_t  way1_data;

    logic               fill;
    dcache_pkg::way_t   fill_way;
    logic               mark_dirty;
    dcache_pkg::way_t   dirty_way;
    logic               touch;
    dcache_pkg::way_t   touch_way;
    logic               hit;
    dcache_pkg::way_t   hit_way;
    dcache_pkg::way_t   victim_way;
    logic               victim_dirty;
    dcache_pkg::tag_t   victim_tag;

    dcache_ctrl u_ctrl (
        .clk            (clk),
        .reset_i        (reset_i),
        .req_valid_i    (req_valid_i),
        .req_write_i    (req_write_i),
        .req_addr_i     (req_addr_i),
        .req_wdata_i    (req_wdata_i),
        .req_strb_i     (req_strb_i),
        .req_ready_o    (req_ready_o),
        .resp_valid_o   (resp_valid_o),
        .resp_rdata_o   (resp_rdata_o),
        .mem_op_o       (mem_op_o),
        .mem_addr_o     (mem_addr_o),
        .mem_wdata_o    (mem_wdata_o),
        .mem_ready_i    (mem_ready_i),
        .mem_rdata_i    (mem_rdata_i),
        .arr_index_o    (arr_index),
        .arr_en_o       (arr_en),
        .way0_we_o      (way0_we),
        .way1_we_o      (way1_we),
        .arr_wtag_o     (arr_wtag),
        .arr_wdata_o    (arr_wdata),
        .way0_data_i    (way0_data),
        .way1_data_i    (way1_data),
        .fill_o         (fill),
        .fill_way_o     (fill_way),
        .mark_dirty_o   (mark_dirty),
        .dirty_way_o    (dirty_way),
        .touch_o        (touch),
        .touch_way_o    (touch_way),
        .hit_i          (hit),
        .hit_way_i      (hit_way),
        .victim_way_i   (victim_way),
        .victim_dirty_i (victim_dirty),
        .victim_tag_i   (victim_tag)
    );

    dcache_lookup u_lookup (
        .clk            (clk),
        .reset_i        (reset_i),
        .index_i        (arr_index),
        .tag_i          (arr_wtag),
        .way0_tag_i     (way0_tag),
        .way1_tag_i     (way1_tag),
        .fill_i         (fill),
        .fill_way_i     (fill_way),
        .mark_dirty_i   (mark_dirty),
        .dirty_way_i    (dirty_way),
        .touch_i        (touch),
        .touch_way_i    (touch_way),
        .hit_o          (hit),
        .hit_way_o      (hit_way),
        .victim_way_o   (victim_way),
        .victim_dirty_o (victim_dirty),
        .victim_tag_o   (victim_tag)
    );

    // tag and data of a way are written together
    dcache_sram #(.entry_t(dcache_pkg::tag_t)) u_tag0 (
        .clk     (clk),
        .en_i    (arr_en),
        .we_i    (way0_we),
        .addr_i  (arr_index),
        .wdata_i (arr_wtag),
        .rdata_o (way0_tag)
    );

    dcache_sram #(.entry_t(dcache_pkg::tag_t)) u_tag1 (
        .clk     (clk),
        .en_i    (arr_en),
        .we_i    (way1_we),
        .addr_i  (arr_index),
        .wdata_i (arr_wtag),
        .rdata_o (way1_tag)
    );

    dcache_sram #(.entry_t(dcache_pkg::word_t)) u_data0 (
        .clk     (clk),
        .en_i    (arr_en),
        .we_i    (way0_we),
        .addr_i  (arr_index),
        .wdata_i (arr_wdata),
        .rdata_o (way0_data)
    );

    dcache_sram #(.entry_t(dcache_pkg::word_t)) u_data1 (
        .clk     (clk),
        .en_i    (arr_en),
        .we_i    (way1_we),
        .addr_i  (arr_index),
        .wdata_i (arr_wdata),
        .rdata_o (way1_data)
    );

endmodule

// ==== verification/dcache_mem_model.sv ====
/*
 * dcache backing memory
 * answers refill and write-back on the line port after a random
 * delay, untouched words read back as their address twice
 */
`timescale 1ns/1ns

module dcache_mem_model (
    input  logic                 clk,
    input  logic                 reset_i,
    input  dcache_pkg::mem_op_t  mem_op_i,
    input  dcache_pkg::addr_t    mem_addr_i,
    input  dcache_pkg::word_t    mem_wdata_i,
    output logic                 mem_ready_o,
    output dcache_pkg::word_t    mem_rdata_o
);

    dcache_pkg::word_t store [dcache_pkg::addr_t];

    integer      seed;
    logic        busy;
    int unsigned wait_cnt;

    initial begin
        seed        = 37;
        mem_ready_o = 1'b0;
        mem_rdata_o = '0;
    end

    function automatic dcache_pkg::word_t read_word(input dcache_pkg::addr_t addr);
        if (store.exists(addr)) begin
            read_word = store[addr];
        end else begin
            read_word = {addr, addr};
        end
    endfunction

    // ready is a single-cycle pulse, the cache drops its op after it
    always @(posedge clk) begin
        if (reset_i) begin
            mem_ready_o <= 1'b0;
            mem_rdata_o <= '0;
            busy        <= 1'b0;
            wait_cnt    <= 0;
        end else if (mem_ready_o) begin
            mem_ready_o <= 1'b0;
            busy        <= 1'b0;
        end else if (mem_op_i != dcache_pkg::MEM_NONE) begin
            if (!busy) begin
                busy     <= 1'b1;
                wait_cnt <= $unsigned($random(seed)) % 6;
            end else if (wait_cnt == 0) begin
                mem_ready_o <= 1'b1;
                if (mem_op_i == dcache_pkg::MEM_REFILL) begin
                    mem_rdata_o <= read_word(mem_addr_i);
                end else begin
                    store[mem_addr_i] = mem_wdata_i;
                end
            end else begin
                wait_cnt <= wait_cnt - 1;
            end
        end
    end

endmodule

// ==== verification/dcache_sva.sv ====
/*
 * dcache protocol assertions
 * reset values, cpu handshake and memory port hold rules,
 * bound into the cache top level
 */
`timescale 1ns/1ns

module dcache_sva (
    input  logic                 clk,
    input  logic                 reset_i,
    input  logic                 req_valid_i,
    input  logic                 req_ready_o,
    input  logic                 resp_valid_o,
    input  dcache_pkg::mem_op_t  mem_op_o,
    input  dcache_pkg::addr_t    mem_addr_o,
    input  dcache_pkg::word_t    mem_wdata_o,
    input  logic                 mem_ready_i
);

    int assert_failures = 0;

    reset_idle: assert property (@(posedge clk)
        reset_i |=> (req_ready_o && !resp_valid_o && mem_op_o == dcache_pkg::MEM_NONE))
        else begin
            assert_failures++;
            $error("cache outputs not idle after reset");
        end

    accept_busy: assert property (@(posedge clk) disable iff (reset_i)
        (req_valid_i && req_ready_o) |=> !req_ready_o)
        else begin
            assert_failures++;
            $error("req_ready_o still high after an accepted request");
        end

    // one response pulse, then ready again
    resp_pulse: assert property (@(posedge clk) disable iff (reset_i)
        resp_valid_o |=> (!resp_valid_o && req_ready_o))
        else begin
            assert_failures++;
            $error("resp_valid_o longer than one cycle or no return to ready");
        end

    mem_hold: assert property (@(posedge clk) disable iff (reset_i)
        (mem_op_o != dcache_pkg::MEM_NONE && !mem_ready_i) |=>
        ($stable(mem_op_o) && $stable(mem_addr_o) && $stable(mem_wdata_o)))
        else begin
            assert_failures++;
            $error("memory request changed while mem_ready_i was low");
        end

    mem_release: assert property (@(posedge clk) disable iff (reset_i)
        (mem_op_o != dcache_pkg::MEM_NONE && mem_ready_i) |=>
        (mem_op_o == dcache_pkg::MEM_NONE))
        else begin
            assert_failures++;
            $error("mem_op_o not back to none after mem_ready_i");
        end

endmodule

bind dcache_top dcache_sva u_sva (
    .clk          (clk),
    .reset_i      (reset_i),
    .req_valid_i  (req_valid_i),
    .req_ready_o  (req_ready_o),
    .resp_valid_o (resp_valid_o),
    .mem_op_o     (mem_op_o),
    .mem_addr_o   (mem_addr_o),
    .mem_wdata_o  (mem_wdata_o),
    .mem_ready_i  (mem_ready_i)
);

// ==== verification/dcache_tb.sv ====
/*
 * dcache testbench
 * drives cpu requests into the cache, keeps a shadow memory for
 * expected read data and logs every memory port transfer
 */
`timescale 1ns/1ns
`include "dcache_cfg.svh"

module dcache_tb;

    localparam int TIMEOUT_CYCLES = 200;

    logic                clk;
    logic                reset_i;
    logic                req_valid_i;
    logic                req_write_i;
    dcache_pkg::addr_t   req_addr_i;
    dcache_pkg::word_t   req_wdata_i;
    dcache_pkg::strb_t   req_strb_i;
    logic                req_ready_o;
    logic                resp_valid_o;
    dcache_pkg::word_t   resp_rdata_o;
    dcache_pkg::mem_op_t mem_op_o;
    dcache_pkg::addr_t   mem_addr_o;
    dcache_pkg::word_t   mem_wdata_o;
    logic                mem_ready_i;
    dcache_pkg::word_t   mem_rdata_i;

    integer seed;
    int     value_errors;
    int     timeouts;
    int     last_latency;
    logic   aborted;

    dcache_pkg::word_t   shadow [dcache_pkg::addr_t];
    dcache_pkg::mem_op_t op_log [$];
    dcache_pkg::addr_t   addr_log [$];
    dcache_pkg::word_t   data_log [$];

    dcache_top dut (
        .clk          (clk),
        .reset_i      (reset_i),
        .req_valid_i  (req_valid_i),
        .req_write_i  (req_write_i),
        .req_addr_i   (req_addr_i),
        .req_wdata_i  (req_wdata_i),
        .req_strb_i   (req_strb_i),
        .req_ready_o  (req_ready_o),
        .resp_valid_o (resp_valid_o),
        .resp_rdata_o (resp_rdata_o),
        .mem_op_o     (mem_op_o),
        .mem_addr_o   (mem_addr_o),
        .mem_wdata_o  (mem_wdata_o),
        .mem_ready_i  (mem_ready_i),
        .mem_rdata_i  (mem_rdata_i)
    );

    dcache_mem_model u_mem (
        .clk         (clk),
        .reset_i     (reset_i),
        .mem_op_i    (mem_op_o),
        .mem_addr_i  (mem_addr_o),
        .mem_wdata_i (mem_wdata_o),
        .mem_ready_o (mem_ready_i),
        .mem_rdata_o (mem_rdata_i)
    );

    always #4 clk = ~clk;

    // completed transfers on the memory port
    always @(posedge clk) begin
        if (!reset_i && mem_op_o != dcache_pkg::MEM_NONE && mem_ready_i) begin
            op_log.push_back(mem_op_o);
            addr_log.push_back(mem_addr_o);
            data_log.push_back(mem_wdata_o);
        end
    end

    function automatic dcache_pkg::addr_t line_addr(input dcache_pkg::addr_t addr);
        line_addr = {addr[`DCACHE_ADDR_W-1:`DCACHE_OFFSET_W], {`DCACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic dcache_pkg::addr_t make_addr(input dcache_pkg::tag_t tag,
                                                    input dcache_pkg::index_t index);
        make_addr = {tag, index, {`DCACHE_OFFSET_W{1'b0}}};
    endfunction

    function automatic dcache_pkg::word_t expected_word(input dcache_pkg::addr_t addr);
        dcache_pkg::addr_t line;
        line = line_addr(addr);
        if (shadow.exists(line)) begin
            expected_word = shadow[line];
        end else begin
            expected_word = {line, line};
        end
    endfunction

    task automatic shadow_store(input dcache_pkg::addr_t addr, input dcache_pkg::word_t wdata,
                                input dcache_pkg::strb_t strb);
        dcache_pkg::word_t word;
        word = expected_word(addr);
        for (int b = 0; b < `DCACHE_STRB_W; b++) begin
            if (strb[b]) begin
                word[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        shadow[line_addr(addr)] = word;
    endtask

    task automatic check_value(input string name, input logic [63:0] actual,
                               input logic [63:0] expected);
        if (!aborted) begin
            assert (actual === expected) else begin
                value_errors++;
                $display("[ERROR] t=%0t %s actual=%h expected=%h",
                         $time, name, actual, expected);
            end
        end
    endtask

    task automatic report_timeout(input string what);
        timeouts++;
        aborted = 1'b1;
        $display("timeout: %s did not happen within %0d cycles", what, TIMEOUT_CYCLES);
    endtask

    // one request from handshake to response, read data checked on the way
    task automatic access(input logic wr, input dcache_pkg::addr_t addr,
                          input dcache_pkg::word_t wdata, input dcache_pkg::strb_t strb);
        dcache_pkg::word_t expected;
        int   cycles;
        logic done;
        if (aborted) return;
        op_log.delete();
        addr_log.delete();
        data_log.delete();
        req_valid_i <= 1'b1;
        req_write_i <= wr;
        req_addr_i  <= addr;
        req_wdata_i <= wdata;
        req_strb_i  <= strb;
        cycles = 0;
        done   = 1'b0;
        while (!done && !aborted) begin
            @(posedge clk);
            if (req_ready_o) begin
                done = 1'b1;
            end else begin
                cycles = cycles + 1;
                if (cycles >= TIMEOUT_CYCLES) begin
                    report_timeout("request handshake");
                end
            end
        end
        req_valid_i <= 1'b0;
        if (aborted) return;
        if (wr) begin
            shadow_store(addr, wdata, strb);
            expected = '0;
        end else begin
            expected = expected_word(addr);
        end
        last_latency = 0;
        done = 1'b0;
        while (!done && !aborted) begin
            @(posedge clk);
            last_latency = last_latency + 1;
            if (resp_valid_o) begin
                done = 1'b1;
                check_value("resp_rdata_o", resp_rdata_o, expected);
            end else if (last_latency >= TIMEOUT_CYCLES) begin
                report_timeout("response");
            end
        end
    endtask

    task automatic expect_refill_only(input dcache_pkg::addr_t addr);
        check_value("mem transfer count", op_log.size(), 1);
        if (op_log.size() == 1) begin
            check_value("mem_op_o", op_log[0], dcache_pkg::MEM_REFILL);
            check_value("mem_addr_o", addr_log[0], line_addr(addr));
        end
    endtask

    task automatic expect_eviction(input dcache_pkg::addr_t victim_addr,
                                   input dcache_pkg::word_t victim_data,
                                   input dcache_pkg::addr_t new_addr);
        check_value("mem transfer count", op_log.size(), 2);
        if (op_log.size() == 2) begin
            check_value("mem_op_o", op_log[0], dcache_pkg::MEM_WRITEBACK);
            check_value("mem_addr_o", addr_log[0], line_addr(victim_addr));
            check_value("mem_wdata_o", data_log[0], victim_data);
            check_value("mem_op_o", op_log[1], dcache_pkg::MEM_REFILL);
            check_value("mem_addr_o", addr_log[1], line_addr(new_addr));
        end
    endtask

    task automatic expect_hit;
        check_value("mem transfer count", op_log.size(), 0);
        check_value("hit latency", last_latency, 3);
    endtask

    initial begin
        dcache_pkg::addr_t addr_a;
        dcache_pkg::addr_t addr_b;
        dcache_pkg::addr_t addr_c;
        dcache_pkg::word_t victim_data;
        dcache_pkg::addr_t rand_addr;
        dcache_pkg::word_t rand_data;
        clk          = 1'b0;
        reset_i      = 1'b1;
        req_valid_i  = 1'b0;
        req_write_i  = 1'b0;
        req_addr_i   = '0;
        req_wdata_i  = '0;
        req_strb_i   = '0;
        seed         = 37;
        value_errors = 0;
        timeouts     = 0;
        last_latency = 0;
        aborted      = 1'b0;
        repeat (3) @(posedge clk);
        reset_i <= 1'b0;
        @(posedge clk);
        check_value("req_ready_o", req_ready_o, 1);
        check_value("resp_valid_o", resp_valid_o, 0);
        check_value("mem_op_o", mem_op_o, dcache_pkg::MEM_NONE);

        // read miss with an unaligned address, then the hit
        addr_a = make_addr(23'h00012, 6'd5) | 32'h4;
        access(1'b0, addr_a, '0, '0);
        expect_refill_only(addr_a);
        access(1'b0, addr_a, '0, '0);
        expect_hit();

        // partial store into the cached word
        access(1'b1, addr_a, 64'hdead_beef_cafe_f00d, 8'b0101_1010);
        expect_hit();
        access(1'b0, addr_a, '0, '0);
        expect_hit();

        // write miss allocates
        addr_b = make_addr(23'h00345, 6'd9);
        access(1'b1, addr_b, 64'h0123_4567_89ab_cdef, 8'h0f);
        expect_refill_only(addr_b);
        access(1'b0, addr_b, '0, '0);
        expect_hit();

        // dirty A in way 0, clean B in way 1, C evicts A
        addr_a = make_addr(23'h00100, 6'd20);
        addr_b = make_addr(23'h00200, 6'd20);
        addr_c = make_addr(23'h00300, 6'd20);
        access(1'b1, addr_a, 64'h1111_2222_3333_4444, 8'hc3);
        expect_refill_only(addr_a);
        access(1'b0, addr_b, '0, '0);
        expect_refill_only(addr_b);
        victim_data = expected_word(addr_a);
        access(1'b0, addr_c, '0, '0);
        expect_eviction(addr_a, victim_data, addr_c);
        access(1'b0, addr_c, '0, '0);
        expect_hit();
        // B is now the clean victim, A comes back from memory
        access(1'b0, addr_a, '0, '0);
        expect_refill_only(addr_a);

        // random mix on two sets for evictions under random memory delays
        for (int i = 0; i < 24; i++) begin
            rand_addr = make_addr(23'h00040 + ($unsigned($random(seed)) % 3),
                                  6'd30 + ($unsigned($random(seed)) % 2));
            rand_data = {$random(seed), $random(seed)};
            access($random(seed) & 1, rand_addr, rand_data, $random(seed));
        end

        repeat (2) @(posedge clk);
        $display("value errors: %0d, timeouts: %0d, assertion failures: %0d",
                 value_errors, timeouts, dut.u_sva.assert_failures);
        if (value_errors == 0 && timeouts == 0 && dut.u_sva.assert_failures == 0) begin
            $display("Simulation completed successfully");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule

// ==== sources.f ====
+incdir+rtl
rtl/dcache_pkg.sv
rtl/dcache_sram.sv
rtl/dcache_lookup.sv
rtl/dcache_ctrl.sv
rtl/dcache_top.sv
verification/dcache_mem_model.sv
verification/dcache_sva.sv
verification/dcache_tb.sv

// ==== Bender.yml ====
package:
  name: dcache

sources:
  - include_dirs:
      - rtl
    files:
      - rtl/dcache_pkg.sv
      - rtl/dcache_sram.sv
      - rtl/dcache_lookup.sv
      - rtl/dcache_ctrl.sv
      - rtl/dcache_top.sv
  - target: simulation
    include_dirs:
      - rtl
    files:
      - verification/dcache_mem_model.sv
      - verification/dcache_sva.sv
      - verification/dcache_tb.sv
